//--- logic/afifo_config.svh
`ifndef AFIFO_CONFIG_SVH
`define AFIFO_CONFIG_SVH

// Word width in bits
`define AFIFO_WIDTH 8

// Entries, must be a power of two and at least 4
`define AFIFO_DEPTH 16

// Address bits, the pointers carry one more for the wrap
`define AFIFO_AW $clog2(`AFIFO_DEPTH)

`endif

//--- logic/afifo_pkg.sv
`default_nettype none

`include "afifo_config.svh"

package afifo_pkg;

	// One data word as stored in the memory
	typedef logic [`AFIFO_WIDTH-1:0] afifo_data_t;

	// Memory address, low bits of a binary pointer
	typedef logic [`AFIFO_AW-1:0] afifo_addr_t;

	// Pointer state kept by each side
	typedef struct packed {
		logic [`AFIFO_AW:0] bin;	// Count with wrap bit
		logic [`AFIFO_AW:0] gray;	// Crosses to the other clock
	} afifo_ptr_t;

	// Shared by both pointer blocks
	function automatic logic [`AFIFO_AW:0] afifo_bin2gray(input logic [`AFIFO_AW:0] bin);
		return bin ^ (bin >> 1);
	endfunction

	// Next pointer, advanced by one when inc is set
	function automatic afifo_ptr_t afifo_ptr_next(input afifo_ptr_t cur, input logic inc);
		afifo_ptr_t nxt;
		nxt.bin = cur.bin + {{`AFIFO_AW{1'b0}}, inc};
		nxt.gray = afifo_bin2gray(nxt.bin);
		return nxt;
	endfunction

endpackage

`default_nettype wire

//--- logic/afifo_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "afifo_config.svh"

module afifo_mem (
	input  logic                  wclk,
	input  logic                  wen,
	input  afifo_pkg::afifo_addr_t waddr,
	input  afifo_pkg::afifo_data_t wdata,
	input  logic                  rclk,
	input  logic                  ren,
	input  afifo_pkg::afifo_addr_t raddr,
	output afifo_pkg::afifo_data_t rdata
);

	import afifo_pkg::*;

	// Storage, no reset
	afifo_data_t mem [`AFIFO_DEPTH];

	// Write port, wen already qualified by the full flag
	always_ff @(posedge wclk) begin
		if (wen) begin
			mem[waddr] <= wdata;
		end
	end

	// Registered read, holds between pops
	always_ff @(posedge rclk) begin
		if (ren) begin
			rdata <= mem[raddr];
		end
	end

endmodule

`default_nettype wire

//--- logic/afifo_wptr.sv
`timescale 1ns/100ps
`default_nettype none

`include "afifo_config.svh"

module afifo_wptr (
	input  logic                 wclk,
	input  logic                 wrstn,
	input  logic                 winc,
	input  logic [`AFIFO_AW:0]   rgray_async,
	output afifo_pkg::afifo_ptr_t wptr,
	output logic                 wen,
	output logic                 wfull
);

	import afifo_pkg::*;

	afifo_ptr_t         wptr_next;
	logic [`AFIFO_AW:0] rgray_meta;
	logic [`AFIFO_AW:0] rgray_sync;
	logic [`AFIFO_AW:0] rgray_full;	// Read pointer one lap behind
	logic               wfull_next;

	// Push accepted
	assign wen = winc & ~wfull;

	always_comb begin
		wptr_next = afifo_ptr_next(wptr, wen);
	end

	always_ff @(posedge wclk or negedge wrstn) begin
		if (!wrstn) begin
			wptr <= '0;
		end else begin
			wptr <= wptr_next;
		end
	end

	// Two flops into the write clock
	always_ff @(posedge wclk or negedge wrstn) begin
		if (!wrstn) begin
			rgray_meta <= '0;
			rgray_sync <= '0;
		end else begin
			rgray_meta <= rgray_async;
			rgray_sync <= rgray_meta;
		end
	end

	// In Gray code a full lap flips the two top bits
	assign rgray_full = {~rgray_sync[`AFIFO_AW:`AFIFO_AW-1], rgray_sync[`AFIFO_AW-2:0]};

	assign wfull_next = (wptr_next.gray == rgray_full);

	// Rises with the push that fills the last slot
	always_ff @(posedge wclk or negedge wrstn) begin
		if (!wrstn) begin
			wfull <= 1'b0;
		end else begin
			wfull <= wfull_next;
		end
	end

	// No slot is overwritten while full
	a_full_holds_ptr: assert property (
		@(posedge wclk) disable iff (!wrstn)
		wfull |=> $stable(wptr.bin)
	) else $error("afifo_wptr: write pointer moved while full");

endmodule

`default_nettype wire

//--- logic/afifo_rptr.sv
`timescale 1ns/100ps
`default_nettype none

`include "afifo_config.svh"

module afifo_rptr (
	input  logic                 rclk,
	input  logic                 rrstn,
	input  logic                 rinc,
	input  logic [`AFIFO_AW:0]   wgray_async,
	output afifo_pkg::afifo_ptr_t rptr,
	output logic                 ren,
	output logic                 rempty
);

	import afifo_pkg::*;

	afifo_ptr_t         rptr_next;
	logic [`AFIFO_AW:0] wgray_meta;
	logic [`AFIFO_AW:0] wgray_sync;
	logic               rempty_next;

	// Pop accepted and rdata loaded in the memory
	assign ren = rinc & ~rempty;

	always_comb begin
		rptr_next = afifo_ptr_next(rptr, ren);
	end

	always_ff @(posedge rclk or negedge rrstn) begin
		if (!rrstn) begin
			rptr <= '0;
		end else begin
			rptr <= rptr_next;
		end
	end

	// Write pointer into the read clock
	always_ff @(posedge rclk or negedge rrstn) begin
		if (!rrstn) begin
			wgray_meta <= '0;
			wgray_sync <= '0;
		end else begin
			wgray_meta <= wgray_async;
			wgray_sync <= wgray_meta;
		end
	end

	// Caught up with every word seen so far
	assign rempty_next = (rptr_next.gray == wgray_sync);

	always_ff @(posedge rclk or negedge rrstn) begin
		if (!rrstn) begin
			rempty <= 1'b1;	// Empty out of reset
		end else begin
			rempty <= rempty_next;
		end
	end

	// Nothing is read past the last written word
	a_empty_holds_ptr: assert property (
		@(posedge rclk) disable iff (!rrstn)
		rempty |=> $stable(rptr.bin)
	) else $error("afifo_rptr: read pointer moved while empty");

	// The pointer sent to the write side moves one Gray bit at a time,
	// so its synchronizer never samples a multi-bit change
	a_gray_step: assert property (
		@(posedge rclk) disable iff (!rrstn)
		$countones(rptr.gray ^ $past(rptr.gray)) <= 1
	) else $error("afifo_rptr: gray pointer changed by more than one bit");

endmodule

`default_nettype wire

//--- logic/afifo_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "afifo_config.svh"

module afifo_top (
	input  logic                  wclk,
	input  logic                  wrstn,
	input  logic                  winc,
	input  afifo_pkg::afifo_data_t wdata,
	output logic                  wfull,
	input  logic                  rclk,
	input  logic                  rrstn,
	input  logic                  rinc,
	output afifo_pkg::afifo_data_t rdata,
	output logic                  rempty
);

	import afifo_pkg::*;

	afifo_ptr_t wptr;	// Write clock
	afifo_ptr_t rptr;	// Read clock
	logic       wen;
	logic       ren;

	// Write side, sees the read pointer through its synchronizer
	afifo_wptr u_wptr (
		.wclk        (wclk),
		.wrstn       (wrstn),
		.winc        (winc),
		.rgray_async (rptr.gray),
		.wptr        (wptr),
		.wen         (wen),
		.wfull       (wfull)
	);

	// Read side
	afifo_rptr u_rptr (
		.rclk        (rclk),
		.rrstn       (rrstn),
		.rinc        (rinc),
		.wgray_async (wptr.gray),
		.rptr        (rptr),
		.ren         (ren),
		.rempty      (rempty)
	);

	// Addresses are the low bits of the binary counts
	afifo_mem u_mem (
		.wclk  (wclk),
		.wen   (wen),
		.waddr (wptr.bin[`AFIFO_AW-1:0]),
		.wdata (wdata),
		.rclk  (rclk),
		.ren   (ren),
		.raddr (rptr.bin[`AFIFO_AW-1:0]),
		.rdata (rdata)
	);

endmodule

`default_nettype wire

//--- dv/tb_clkgen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen #(
	parameter real half_period = 5.0	// ns
) (
	output logic clk
);

	// Low at time zero, first rising edge after one half period
	initial begin
		clk = 1'b0;
		forever begin
			#(half_period) clk = ~clk;
		end
	end

endmodule

`default_nettype wire

//--- dv/afifo_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "afifo_config.svh"

module afifo_tb;

	import afifo_pkg::*;

	localparam int reset_cycles = 16;
	localparam int words_total = 2000;
	localparam int chunk_words = words_total / 4;
	// Read clock cycles, about three per word plus the fill and drain tests
	localparam int planned_cycles = reset_cycles + 3 * words_total
		+ 3 * (2 * `AFIFO_DEPTH + 40);
	localparam int timeout_cycles = 4 * planned_cycles;

	logic        wclk;
	logic        rclk;
	logic        wrstn = 1'b0;
	logic        rrstn = 1'b0;
	logic        winc = 1'b0;
	afifo_data_t wdata = '0;
	logic        rinc = 1'b0;
	logic        wfull;
	logic        rempty;
	afifo_data_t rdata;

	int unsigned w_duty = 0;	// Percent of write cycles with winc high
	int unsigned r_duty = 0;
	logic [31:0] w_state = 32'hf73e;
	logic [31:0] r_state = 32'hf73e ^ 32'h5bd1e995;	// Separate stream per clock

	afifo_data_t model_q[$];	// Every accepted word in order
	int          rd_index = 0;	// Oldest word not yet popped
	afifo_data_t last_word = '0;
	bit          have_word = 1'b0;
	int          rst_count = 0;
	int          cycles = 0;

	// 7 ns against 10 ns, the edges never line up
	tb_clkgen #(
		.half_period (3.5)
	) u_wclk_gen (
		.clk (wclk)
	);

	tb_clkgen #(
		.half_period (5.0)
	) u_rclk_gen (
		.clk (rclk)
	);

	afifo_top uut (
		.wclk   (wclk),
		.wrstn  (wrstn),
		.winc   (winc),
		.wdata  (wdata),
		.wfull  (wfull),
		.rclk   (rclk),
		.rrstn  (rrstn),
		.rinc   (rinc),
		.rdata  (rdata),
		.rempty (rempty)
	);

	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int model_count();
		return model_q.size() - rd_index;
	endfunction

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	// Both resets released together after 16 read clock cycles
	always @(posedge rclk) begin
		if (rst_count == reset_cycles) begin
			rrstn <= 1'b1;
			wrstn <= 1'b1;
		end else begin
			rst_count <= rst_count + 1;
		end
	end

	always @(posedge wclk) begin
		if (!wrstn) begin
			winc <= 1'b0;
		end else begin
			w_state = next_random(w_state);
			winc <= (w_state % 32'd100) < w_duty;
			w_state = next_random(w_state);
			wdata <= w_state[`AFIFO_WIDTH-1:0];
		end
	end

	always @(posedge rclk) begin
		if (!rrstn) begin
			rinc <= 1'b0;
		end else begin
			r_state = next_random(r_state);
			rinc <= (r_state % 32'd100) < r_duty;
		end
	end

	// Write side of the model, values seen here are the ones before the edge
	always @(posedge wclk) begin
		if (wrstn) begin
			if (model_count() == `AFIFO_DEPTH) begin
				assert (wfull) else
					stop_on_error($sformatf("ERR wfull: got %h, expected %h with the FIFO full",
						wfull, 1'b1));
			end
			if (winc && !wfull) begin
				model_q.push_back(wdata);
			end
		end
	end

	// Read side, rdata holds the last popped word until the next pop
	always @(posedge rclk) begin
		if (rrstn) begin
			if (have_word) begin
				assert (rdata == last_word) else
					stop_on_error($sformatf("ERR rdata: got %h, expected %h", rdata, last_word));
			end
			if (model_count() == 0) begin
				assert (rempty) else
					stop_on_error($sformatf("ERR rempty: got %h, expected %h with the FIFO empty",
						rempty, 1'b1));
			end
			if (rinc && !rempty && model_count() > 0) begin
				last_word = model_q[rd_index];
				rd_index = rd_index + 1;
				have_word = 1'b1;
			end
		end
	end

	always @(posedge rclk) begin
		cycles <= cycles + 1;
		if (cycles == timeout_cycles) begin
			stop_on_error($sformatf("Timeout: the run did not finish within %0d read clock cycles",
				timeout_cycles));
		end
	end

	// Both sides idle long enough for the pointers to cross
	task automatic stop_traffic();
		w_duty = 0;
		r_duty = 0;
		repeat (4) @(negedge wclk);
		repeat (4) @(negedge rclk);
	endtask

	task automatic random_traffic(input int unsigned wpct, input int unsigned rpct,
		input int words);
		int target;
		target = rd_index + words;
		w_duty = wpct;
		r_duty = rpct;
		while (rd_index < target) begin
			@(negedge rclk);
		end
	endtask

	task automatic drain_and_check();
		int expected;
		int base;
		int quiet;
		stop_traffic();
		expected = model_count();
		base = rd_index;
		quiet = 0;
		r_duty = 100;
		// Pops keep going while empty, rdata must hold meanwhile
		while (quiet < 8) begin
			@(negedge rclk);
			if (rempty) begin
				quiet = quiet + 1;
			end else begin
				quiet = 0;
			end
		end
		assert (rd_index - base == expected) else
			stop_on_error($sformatf("ERR pop count: got %h, expected %h",
				rd_index - base, expected));
		r_duty = 0;
	endtask

	task automatic fill_and_check();
		int base;
		stop_traffic();
		base = model_q.size();
		assert (model_count() == 0) else
			stop_on_error($sformatf("ERR model count: got %h before the fill, expected %h",
				model_count(), 0));
		w_duty = 100;
		while (!wfull) begin
			@(negedge wclk);
		end
		assert (model_q.size() - base == `AFIFO_DEPTH) else
			stop_on_error($sformatf("ERR push count: got %h when wfull rose, expected %h",
				model_q.size() - base, `AFIFO_DEPTH));
		repeat (20) begin
			@(negedge wclk);
			assert (wfull) else
				stop_on_error($sformatf("ERR wfull: got %h while full, expected %h", wfull, 1'b1));
		end
		assert (model_q.size() - base == `AFIFO_DEPTH) else
			stop_on_error($sformatf("ERR push count: got %h after pushes into a full FIFO, expected %h",
				model_q.size() - base, `AFIFO_DEPTH));
		w_duty = 0;
	endtask

	initial begin
		while (!rrstn) begin
			@(negedge rclk);
		end
		@(negedge rclk);
		assert (wfull == 1'b0) else
			stop_on_error($sformatf("ERR wfull: got %h after reset, expected %h", wfull, 1'b0));
		assert (rempty == 1'b1) else
			stop_on_error($sformatf("ERR rempty: got %h after reset, expected %h", rempty, 1'b1));

		// Duty cycles move the FIFO between nearly empty and nearly full
		random_traffic(50, 70, chunk_words);
		random_traffic(70, 40, chunk_words);
		random_traffic(30, 90, chunk_words);
		random_traffic(60, 50, chunk_words);

		drain_and_check();
		fill_and_check();
		drain_and_check();

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+logic
logic/afifo_pkg.sv
logic/afifo_mem.sv
logic/afifo_wptr.sv
logic/afifo_rptr.sv
logic/afifo_top.sv
dv/tb_clkgen.sv
dv/afifo_tb.sv

//--- Makefile
# Verilator build and run of the async FIFO testbench
# Override any variable on the command line, e.g. make test OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= afifo_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL CHECKS PASSED

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

# The run passes only when the pass line shows up in the output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
